//--- design/peIngressPkg.sv
package peIngressPkg;

    // Host packet width and node tag width
    localparam int PKT_W = 14;
    localparam int NODE_W = 4;

    // PE node count
    localparam int NUM_NODES = 4;
    // Node select bits on the host word address
    localparam int NODE_SEL_W = $clog2(NUM_NODES);

    // Per-node instruction FIFO entries
    localparam int FIFO_DEPTH = 16;
    // Router side queue entries
    localparam int EGRESS_DEPTH = 4;

    // Saturating ack credit counter
    localparam int CREDIT_W = 3;
    localparam int CREDIT_MAX = (1 << CREDIT_W) - 1;

    // Wishbone data bus width
    localparam int WB_DAT_W = 32;

    // Host packet, bit 0 is ifmap(0) or filter(1), bit 1 is timestep
    // Filter body holds the row, ifmap body holds x and y locations
    typedef struct packed {
        logic [PKT_W-3:0] body;
        logic             timestep;
        logic             isFilter;
    } instPktT;

    // Router packet, payload above node number
    typedef struct packed {
        instPktT           pkt;
        logic [NODE_W-1:0] node;
    } tagPktT;

    // Wishbone classic request
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [NODE_SEL_W-1:0] adr;
        logic [WB_DAT_W-1:0]   dat;
    } wbReqT;

    // Wishbone classic response
    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wbRspT;

endpackage

//--- design/pktFifo.sv
`timescale 1ns/100ps

module pktFifo #(
    parameter int  DEPTH    = 16,
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    // Write side
    input  logic    pushValid,
    input  payloadT pushData,
    // Read side
    input  logic    popReady,
    output logic    popValid,
    output payloadT popData,
    output logic    full
);

    // Pointers carry one extra wrap bit
    logic [$clog2(DEPTH):0] wrPtr;
    logic [$clog2(DEPTH):0] rdPtr;
    logic                   doPush;
    logic                   doPop;

    // Storage, no reset
    payloadT mem [DEPTH];

    // Same index, different wrap bit means full
    assign full = (wrPtr[$clog2(DEPTH)] != rdPtr[$clog2(DEPTH)]) &&
                  (wrPtr[$clog2(DEPTH)-1:0] == rdPtr[$clog2(DEPTH)-1:0]);

    // Equal pointers means empty
    assign popValid = (wrPtr != rdPtr);

    assign doPush = pushValid && !full;
    assign doPop = popValid && popReady;

    // Head read straight from the array
    assign popData = mem[rdPtr[$clog2(DEPTH)-1:0]];

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr[$clog2(DEPTH)-1:0]] <= pushData;
        end
    end

    // Pointer update
    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

endmodule

//--- design/instFifo.sv
`timescale 1ns/100ps

module instFifo import peIngressPkg::*; #(
    parameter int NODE = 0
) (
    input  logic    clk,
    input  logic    rst,
    // From the host slave
    input  logic    pushValid,
    input  instPktT pushPkt,
    output logic    full,
    // One-cycle ack pulse from the PE
    input  logic    peAck,
    // Toward the arbiter
    input  logic    outReady,
    output logic    outValid,
    output tagPktT  outPkt
);

    logic                headValid;
    instPktT             headPkt;
    logic                headGated;
    logic                pop;
    logic                useCredit;
    logic [CREDIT_W-1:0] credits;

    pktFifo #(
        .DEPTH    (FIFO_DEPTH),
        .payloadT (instPktT)
    ) i_pktFifo (
        .clk       (clk),
        .rst       (rst),
        .pushValid (pushValid),
        .pushData  (pushPkt),
        .popReady  (pop),
        .popValid  (headValid),
        .popData   (headPkt),
        .full      (full)
    );

    // New ifmap set, waits for a PE ack
    assign headGated = !headPkt.isFilter && !headPkt.timestep;

    // Gated head held while no credit left
    assign outValid = headValid && (!headGated || (credits != '0));
    assign pop = outValid && outReady;

    // Gated head spends one credit on transfer
    assign useCredit = pop && headGated;

    // Node number in the low bits
    assign outPkt = '{pkt: headPkt, node: NODE_W'(NODE)};

    // Credit counter
    // Early acks are banked up to CREDIT_MAX
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= '0;
        end else if (useCredit && !peAck) begin
            credits <= credits - 1'b1;
        end else if (!useCredit && peAck && (credits != CREDIT_W'(CREDIT_MAX))) begin
            credits <= credits + 1'b1;
        end
        // Ack together with a spend leaves the count as is
    end

endmodule

//--- design/wbIngress.sv
`timescale 1ns/100ps

module wbIngress import peIngressPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    // Host Wishbone slave
    input  wbReqT                hostReq,
    output wbRspT                hostRsp,
    // Node FIFO write side
    input  logic [NUM_NODES-1:0] full,
    output logic [NUM_NODES-1:0] pushValid,
    output instPktT              pushPkt
);

    logic                ackQ;
    logic                canAck;
    logic [WB_DAT_W-1:0] rdDatQ;

    // Ack one cycle after stb
    // Writes wait while the target FIFO is full
    assign canAck = hostReq.cyc && hostReq.stb && !ackQ &&
                    (!hostReq.we || !full[hostReq.adr]);

    always_ff @(posedge clk) begin
        if (rst) begin
            ackQ <= 1'b0;
        end else begin
            ackQ <= canAck;
        end
    end

    // Status word, not-full flag per node
    always_ff @(posedge clk) begin
        if (canAck && !hostReq.we) begin
            rdDatQ <= WB_DAT_W'(~full);
        end
    end

    // Master still holds adr and dat during the ack cycle
    // so the push strobe decodes them directly
    always_comb begin
        pushValid = '0;
        for (int n = 0; n < NUM_NODES; n++) begin
            if (ackQ && hostReq.we && (hostReq.adr == NODE_SEL_W'(n))) begin
                pushValid[n] = 1'b1;
            end
        end
    end

    // Low 14 bits carry the packet
    assign pushPkt = hostReq.dat[PKT_W-1:0];

    assign hostRsp = '{ack: ackQ, dat: rdDatQ};

endmodule

//--- design/nodeArbiter.sv
`timescale 1ns/100ps

module nodeArbiter import peIngressPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    // Node streams
    input  logic [NUM_NODES-1:0] reqValid,
    input  tagPktT               reqPkt [NUM_NODES],
    output logic [NUM_NODES-1:0] reqReady,
    // Merged stream
    input  logic                 mergeReady,
    output logic                 mergeValid,
    output tagPktT               mergePkt
);

    logic [NODE_SEL_W-1:0] lastQ;
    logic [NODE_SEL_W-1:0] scanIdx;
    logic [NODE_SEL_W-1:0] grantIdx;
    logic                  anyValid;

    // Search starts at the node after the last grant
    // Index wraps through the natural width, node count is a power of two
    always_comb begin
        anyValid = 1'b0;
        grantIdx = lastQ;
        scanIdx = lastQ;
        for (int i = 0; i < NUM_NODES; i++) begin
            scanIdx = lastQ + NODE_SEL_W'(i + 1);
            if (!anyValid && reqValid[scanIdx]) begin
                anyValid = 1'b1;
                grantIdx = scanIdx;
            end
        end
    end

    assign mergeValid = anyValid;
    assign mergePkt = reqPkt[grantIdx];

    // Only the granted node sees ready
    always_comb begin
        reqReady = '0;
        reqReady[grantIdx] = anyValid && mergeReady;
    end

    // Pointer moves on a transfer only
    // Node 0 first after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            lastQ <= NODE_SEL_W'(NUM_NODES - 1);
        end else if (anyValid && mergeReady) begin
            lastQ <= grantIdx;
        end
    end

endmodule

//--- design/wbEgress.sv
`timescale 1ns/100ps

module wbEgress import peIngressPkg::*; (
    input  logic   clk,
    input  logic   rst,
    // Merged stream from the arbiter
    input  logic   mergeValid,
    input  tagPktT mergePkt,
    output logic   mergeReady,
    // Router Wishbone master
    input  wbRspT  routerRsp,
    output wbReqT  routerReq
);

    logic   qFull;
    logic   headValid;
    tagPktT headPkt;
    logic   pop;
    logic   busyQ;
    tagPktT reqPktQ;

    // Short egress queue
    pktFifo #(
        .DEPTH    (EGRESS_DEPTH),
        .payloadT (tagPktT)
    ) i_egressQ (
        .clk       (clk),
        .rst       (rst),
        .pushValid (mergeValid),
        .pushData  (mergePkt),
        .popReady  (pop),
        .popValid  (headValid),
        .popData   (headPkt),
        .full      (qFull)
    );

    // Full queue stalls the arbiter and the node FIFOs behind it
    assign mergeReady = !qFull;

    // Head leaves the queue on router ack
    assign pop = busyQ && routerRsp.ack;

    // Bus cycle open from load until ack
    always_ff @(posedge clk) begin
        if (rst) begin
            busyQ <= 1'b0;
        end else if (pop) begin
            busyQ <= 1'b0;
        end else if (headValid) begin
            busyQ <= 1'b1;
        end
    end

    // Request payload latched at load, stable until ack
    always_ff @(posedge clk) begin
        if (!busyQ && headValid) begin
            reqPktQ <= headPkt;
        end
    end

    // Single router port, adr stays zero
    assign routerReq = '{cyc: busyQ, stb: busyQ, we: busyQ, adr: '0,
                         dat: WB_DAT_W'(reqPktQ)};

endmodule

//--- design/peIngressTop.sv
`timescale 1ns/100ps

module peIngressTop import peIngressPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    // Host side
    input  wbReqT                hostReq,
    output wbRspT                hostRsp,
    // PE ack pulses, one per node
    input  logic [NUM_NODES-1:0] peAck,
    // Router side
    input  wbRspT                routerRsp,
    output wbReqT                routerReq
);

    logic [NUM_NODES-1:0] pushValid;
    instPktT              pushPkt;
    logic [NUM_NODES-1:0] full;
    logic [NUM_NODES-1:0] outValid;
    logic [NUM_NODES-1:0] outReady;
    tagPktT               outPkt [NUM_NODES];
    logic                 mergeValid;
    logic                 mergeReady;
    tagPktT               mergePkt;

    wbIngress i_wbIngress (
        .clk       (clk),
        .rst       (rst),
        .hostReq   (hostReq),
        .hostRsp   (hostRsp),
        .full      (full),
        .pushValid (pushValid),
        .pushPkt   (pushPkt)
    );

    // One instruction FIFO per PE node
    for (genvar n = 0; n < NUM_NODES; n++) begin : g_node
        instFifo #(
            .NODE (n)
        ) i_instFifo (
            .clk       (clk),
            .rst       (rst),
            .pushValid (pushValid[n]),
            .pushPkt   (pushPkt),
            .full      (full[n]),
            .peAck     (peAck[n]),
            .outReady  (outReady[n]),
            .outValid  (outValid[n]),
            .outPkt    (outPkt[n])
        );
    end

    nodeArbiter i_nodeArbiter (
        .clk        (clk),
        .rst        (rst),
        .reqValid   (outValid),
        .reqPkt     (outPkt),
        .reqReady   (outReady),
        .mergeReady (mergeReady),
        .mergeValid (mergeValid),
        .mergePkt   (mergePkt)
    );

    wbEgress i_wbEgress (
        .clk        (clk),
        .rst        (rst),
        .mergeValid (mergeValid),
        .mergePkt   (mergePkt),
        .mergeReady (mergeReady),
        .routerRsp  (routerRsp),
        .routerReq  (routerReq)
    );

endmodule

//--- sim/peIngressTb_checker.sv
`timescale 1ns/100ps

module peIngressTb_checker import peIngressPkg::*; (
    input logic                 clk,
    input logic                 rst,
    input wbRspT                hostRsp,
    input wbReqT                routerReq,
    input wbRspT                routerRsp,
    input logic [NUM_NODES-1:0] peAck
);

    // Failed assertions so far, watched by the testbench
    int errCount = 0;
    int ackCnt [NUM_NODES];
    int gatedCnt [NUM_NODES];
    logic routerXfer;

    assign routerXfer = routerReq.stb && routerRsp.ack;

    // Running totals of acks and of gated packets seen on the router
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int n = 0; n < NUM_NODES; n++) begin
                ackCnt[n] <= 0;
                gatedCnt[n] <= 0;
            end
        end else begin
            for (int n = 0; n < NUM_NODES; n++) begin
                if (peAck[n]) begin
                    ackCnt[n] <= ackCnt[n] + 1;
                end
                // Ifmap with timestep 0, tagged for node n
                if (routerXfer && !routerReq.dat[4] && !routerReq.dat[5] &&
                    (routerReq.dat[3:0] == NODE_W'(n))) begin
                    gatedCnt[n] <= gatedCnt[n] + 1;
                end
            end
        end
    end

    // Bus quiet right after reset
    assert property (@(posedge clk) rst |=> !hostRsp.ack && !routerReq.stb)
        else begin
            errCount++;
            $error("Bus active after reset");
        end

    // Router request held stable until ack
    assert property (@(posedge clk) disable iff (rst)
        routerReq.stb && !routerRsp.ack |=> routerReq.stb && $stable(routerReq.dat))
        else begin
            errCount++;
            $error("Router request dropped or changed before ack");
        end

    // Router cycle is a write to the single router address
    assert property (@(posedge clk) disable iff (rst)
        routerReq.stb |-> routerReq.cyc && routerReq.we && (routerReq.adr == '0))
        else begin
            errCount++;
            $error("Router request without cyc, without we or at a nonzero address");
        end

    for (genvar n = 0; n < NUM_NODES; n++) begin : g_gate
        // Never more gated releases than acks
        assert property (@(posedge clk) disable iff (rst) gatedCnt[n] <= ackCnt[n])
            else begin
                errCount++;
                $error("Gated packet released without ack");
            end
    end

endmodule

bind peIngressTop peIngressTb_checker i_checker (
    .clk       (clk),
    .rst       (rst),
    .hostRsp   (hostRsp),
    .routerReq (routerReq),
    .routerRsp (routerRsp),
    .peAck     (peAck)
);

//--- sim/peIngressTb.sv
`timescale 1ns/100ps

module peIngressTb import peIngressPkg::*; ();

    localparam int MAX_CYCLES = 4000;

    logic                 clk = 1'b0;
    logic                 rst;
    wbReqT                hostReq;
    wbRspT                hostRsp;
    logic [NUM_NODES-1:0] peAck;
    wbRspT                routerRsp;
    wbReqT                routerReq;

    // Scoreboard state
    logic [PKT_W-1:0] expQ [NUM_NODES][$];
    int               credit [NUM_NODES];
    int               fairHist [$];
    logic             fairOn = 1'b0;
    logic             routerStall = 1'b0;
    logic             writeDone;
    logic [15:0]      lfsr = 16'd51416;
    int               cycles = 0;
    logic [31:0]      status;

    peIngressTop i_dut (
        .clk       (clk),
        .rst       (rst),
        .hostReq   (hostReq),
        .hostRsp   (hostRsp),
        .peAck     (peAck),
        .routerRsp (routerRsp),
        .routerReq (routerReq)
    );

    always #2 clk = ~clk;

    // Galois LFSR, one step per bit
    function automatic logic nextBit();
        logic lsb;
        lsb = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) begin
            lfsr = lfsr ^ 16'hB400;
        end
        return lsb;
    endfunction

    function automatic logic [11:0] randBody();
        logic [11:0] b;
        for (int i = 0; i < 12; i++) begin
            b[i] = nextBit();
        end
        return b;
    endfunction

    task automatic failRun(string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    // Run limit and checker watch
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1);
        end
        if (i_dut.i_checker.errCount != 0) begin
            $display("A bound assertion failed at %0t ns", $time);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

    // Host master, entered 1 ns after an edge
    task automatic hostWrite(int node, logic [PKT_W-1:0] pkt);
        expQ[node].push_back(pkt);
        hostReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: node[1:0], dat: 32'(pkt)};
        do @(posedge clk); while (!hostRsp.ack);
        #1 hostReq = '0;
    endtask

    task automatic hostRead(output logic [31:0] d);
        hostReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: '0, dat: '0};
        do @(posedge clk); while (!hostRsp.ack);
        d = hostRsp.dat;
        #1 hostReq = '0;
    endtask

    task automatic pulseAck(int node);
        peAck[node] = 1'b1;
        @(posedge clk);
        #1 peAck[node] = 1'b0;
        if (credit[node] < CREDIT_MAX) begin
            credit[node]++;
        end
    endtask

    // Compare one router transfer with the expected queue
    task automatic checkTransfer(logic [17:0] d);
        int node;
        logic [PKT_W-1:0] pkt;
        logic allLoaded;
        node = d[NODE_W-1:0];
        pkt = d[17:NODE_W];
        if (node >= NUM_NODES) failRun($sformatf("bad node tag %0d", node));
        if (expQ[node].size() == 0) failRun($sformatf("unexpected packet for node %0d", node));
        if (expQ[node][0] != pkt) begin
            failRun($sformatf("node %0d got %h, expected %h", node, pkt, expQ[node][0]));
        end
        // Round-robin window while every node stays backed up
        allLoaded = 1'b1;
        for (int n = 0; n < NUM_NODES; n++) begin
            if (expQ[n].size() < 3) allLoaded = 1'b0;
        end
        void'(expQ[node].pop_front());
        if (!pkt[0] && !pkt[1]) begin
            if (credit[node] == 0) failRun($sformatf("gated packet on node %0d, no credit", node));
            credit[node]--;
        end
        if (fairOn && allLoaded) begin
            fairHist.push_back(node);
            if (fairHist.size() > NUM_NODES) void'(fairHist.pop_front());
            if (fairHist.size() == NUM_NODES) begin
                for (int n = 0; n < NUM_NODES; n++) begin
                    if (!(n inside {fairHist})) failRun($sformatf("node %0d skipped", n));
                end
            end
        end else begin
            fairHist = {};
        end
    endtask

    // Router slave with 0 to 3 cycles of ack delay
    initial begin
        int delay;
        forever begin
            @(posedge clk);
            if (routerReq.stb && !routerStall) begin
                delay = {nextBit(), nextBit()};
                repeat (delay) @(posedge clk);
                #1 routerRsp.ack = 1'b1;
                @(posedge clk);
                checkTransfer(routerReq.dat[17:0]);
                #1 routerRsp.ack = 1'b0;
            end
        end
    end

    task automatic drain();
        int left;
        do begin
            @(posedge clk);
            left = 0;
            for (int n = 0; n < NUM_NODES; n++) left += expQ[n].size();
        end while (left != 0);
        repeat (4) @(posedge clk);
        #1;
    endtask

    initial begin
        rst = 1'b1;
        hostReq = '0;
        peAck = '0;
        routerRsp = '0;
        for (int n = 0; n < NUM_NODES; n++) credit[n] = 0;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        // Filter order and node tags
        for (int i = 0; i < 5; i++) begin
            for (int n = 0; n < NUM_NODES; n++) hostWrite(n, {randBody(), 2'b01});
        end
        drain();

        // Gated ifmap waits for ack, timestep 1 follows
        hostWrite(2, {randBody(), 2'b00});
        hostWrite(2, {randBody(), 2'b10});
        repeat (20) @(posedge clk);
        #1;
        if (expQ[2].size() != 2) failRun("gated ifmap left node 2 before its ack");
        pulseAck(2);
        drain();

        // Early acks banked, capped at seven
        for (int i = 0; i < 3; i++) pulseAck(3);
        for (int i = 0; i < 3; i++) hostWrite(3, {randBody(), 2'b00});
        drain();
        for (int i = 0; i < 9; i++) pulseAck(1);
        for (int i = 0; i < 7; i++) hostWrite(1, {randBody(), 2'b00});
        drain();
        hostWrite(1, {randBody(), 2'b00});
        repeat (20) @(posedge clk);
        #1;
        if (expQ[1].size() != 1) failRun("credit count went above seven");
        pulseAck(1);
        drain();

        // Host back-pressure from a full node FIFO
        routerStall = 1'b1;
        for (int i = 0; i < 4; i++) hostWrite(1, {randBody(), 2'b01});
        for (int i = 0; i < FIFO_DEPTH; i++) hostWrite(0, {randBody(), 2'b01});
        repeat (4) @(posedge clk);
        #1 hostRead(status);
        if (status[0]) failRun("status shows node 0 not full with 16 entries");
        writeDone = 1'b0;
        fork
            begin
                hostWrite(0, {randBody(), 2'b01});
                writeDone = 1'b1;
            end
        join_none
        repeat (10) @(posedge clk);
        #1;
        if (writeDone) failRun("seventeenth write acked while node 0 was full");
        routerStall = 1'b0;
        wait (writeDone);
        drain();
        hostRead(status);
        if (status[3:0] != 4'hF) failRun($sformatf("status %h after drain", status[3:0]));

        // Fairness with all four nodes loaded
        routerStall = 1'b1;
        for (int i = 0; i < 6; i++) begin
            for (int n = 0; n < NUM_NODES; n++) hostWrite(n, {randBody(), 2'b11});
        end
        fairOn = 1'b1;
        routerStall = 1'b0;
        drain();
        fairOn = 1'b0;

        repeat (5) @(posedge clk);
        if (i_dut.i_checker.errCount == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

endmodule

//--- peIngressTop.f
design/peIngressPkg.sv
design/pktFifo.sv
design/instFifo.sv
design/wbIngress.sv
design/nodeArbiter.sv
design/wbEgress.sv
design/peIngressTop.sv
sim/peIngressTb_checker.sv
sim/peIngressTb.sv

//--- Bender.yml
package:
  name: pe_ingress

sources:
  - design/peIngressPkg.sv
  - design/pktFifo.sv
  - design/instFifo.sv
  - design/wbIngress.sv
  - design/nodeArbiter.sv
  - design/wbEgress.sv
  - design/peIngressTop.sv
  - target: simulation
    files:
      - sim/peIngressTb_checker.sv
      - sim/peIngressTb.sv
